// File: flist.f
+incdir+verif
source/router_stats_pkg.sv
source/apb_reg_access.sv
source/router_port_regs.sv
source/port_stats_counters.sv
source/router_stats_top.sv
verif/router_stats_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the router statistics testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module router_stats_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vrouter_stats_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: verif/router_stats_tasks.svh
// Bus and packet drivers, count model and directed tests for the router statistics testbench
// Included inside the testbench module body

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

// Counter add that sticks at the all-ones value of the given width
function automatic logic [31:0] add_clamped(input logic [31:0] cur, input logic [31:0] inc,
                                            input int width);
    longint unsigned sum;
    longint unsigned top;
    top = (64'd1 << width) - 1;
    sum = longint'(cur) + longint'(inc);
    return (sum > top) ? top[31:0] : sum[31:0];
endfunction

task automatic count_into(input bit egress, input int port, input int idx, input int inc);
    if (egress) egr_model[port][idx] = add_clamped(egr_model[port][idx], inc, 16);
    else        ing_model[port][idx] = add_clamped(ing_model[port][idx], inc, 32);
endtask

////////////////////////////////////////
// APB master

task automatic apb_transfer(input bit write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(negedge core_clk_ifc);                    // Setup phase
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge core_clk_ifc);
    penable = 1'b1;
    waited  = 0;
    do begin
        @(negedge core_clk_ifc);
        waited++;
    end while (!pready && waited < APB_WAIT_LIMIT);
    if (!pready) begin
        $display("APB transfer to 0x%03h never got pready", addr);
        $display("TESTS FAILED");
        $fatal(1);
    end
    check_value("pready wait cycles", 32'(waited), 32'd1);   // One wait state
    rdata = prdata;
    err   = pslverr;
    @(negedge core_clk_ifc);                    // Transfer done at the edge before
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic reg_write(input int word, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, APB_ADDR_W'(word * 4), data, rd, err);
    check_value($sformatf("pslverr on write to word %0d", word), 32'(err), 32'h0);
endtask

task automatic reg_read(input int word, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, APB_ADDR_W'(word * 4), 32'h0, data, err);
    check_value($sformatf("pslverr on read of word %0d", word), 32'(err), 32'h0);
endtask

////////////////////////////////////////
// Port drivers

task automatic set_enable(input bit egress, input logic [7:0] bits);
    logic [31:0] rd;
    logic [7:0]  mask;
    int          word;
    mask = 8'((1 << (egress ? NUM_EGR : NUM_ING)) - 1);
    word = egress ? ADDR_EGR_ENABLE : ADDR_ING_ENABLE;
    reg_write(word, 32'(bits));
    repeat (2) @(negedge core_clk_ifc);         // Output follows one edge later
    reg_read(word, rd);
    check_value("enable read-back", rd & 32'(mask), 32'(bits & mask));
    if (egress) begin
        check_value("egr_port_enable", 32'(egr_port_enable), 32'(bits & mask));
        egr_en_model = bits & mask;
    end else begin
        check_value("ing_port_enable", 32'(ing_port_enable), 32'(bits & mask));
        ing_en_model = bits & mask;
    end
endtask

task automatic send_packet(input bit egress, input int port, input logic [15:0] len,
                           input bit err);
    @(negedge core_clk_ifc);
    if (egress) begin
        egr_pkt_valid[port] = 1'b1;
        egr_pkt_len[port]   = len;
        egr_pkt_err[port]   = err;
    end else begin
        ing_pkt_valid[port] = 1'b1;
        ing_pkt_len[port]   = len;
        ing_pkt_err[port]   = err;
    end
    if (egress ? egr_en_model[port] : ing_en_model[port]) begin   // Disabled ports ignore
        count_into(egress, port, CNT_PKTS, 1);
        count_into(egress, port, CNT_BYTES, int'(len));
        if (err) count_into(egress, port, CNT_ERRS, 1);
    end
    @(negedge core_clk_ifc);
    ing_pkt_valid = '0;
    ing_pkt_err   = '0;
    egr_pkt_valid = '0;
    egr_pkt_err   = '0;
endtask

task automatic send_drop(input bit egress, input int port);
    @(negedge core_clk_ifc);
    if (egress) egr_buf_full_drop[port] = 1'b1;
    else        ing_buf_full_drop[port] = 1'b1;
    if (egress ? egr_en_model[port] : ing_en_model[port]) count_into(egress, port, CNT_DROPS, 1);
    @(negedge core_clk_ifc);
    ing_buf_full_drop = '0;
    egr_buf_full_drop = '0;
endtask

// Raise sample bits, compare the snapshots and clear the model of sampled ports
task automatic sample_and_check(input bit egress, input logic [7:0] mask);
    logic [31:0] rd;
    logic [31:0] expected;
    int          base;
    int          word;
    word = egress ? ADDR_EGR_SAMPLE : ADDR_ING_SAMPLE;
    reg_write(word, 32'h0);
    reg_write(word, 32'(mask));
    repeat (2) @(negedge core_clk_ifc);         // Snapshot loads two edges after the write
    for (int p = 0; p < (egress ? NUM_EGR : NUM_ING); p++) begin
        if (mask[p]) begin
            base = ADDR_CNT_BASE + NUM_CNT_PER_PORT * (egress ? NUM_ING + p : p);
            for (int c = 0; c < NUM_CNT_PER_PORT; c++) begin
                reg_read(base + c, rd);
                if (egress) begin
                    expected        = egr_model[p][c];
                    egr_model[p][c] = '0;
                end else begin
                    expected        = ing_model[p][c];
                    ing_model[p][c] = '0;
                end
                check_value($sformatf("%s port %0d counter %0d snapshot",
                            egress ? "egress" : "ingress", p, c), rd, expected);
            end
        end
    end
endtask

////////////////////////////////////////
// Directed tests

task automatic verify_reset_identity();
    logic [31:0] rd;
    check_value("pready after reset", 32'(pready), 32'h0);
    check_value("pslverr after reset", 32'(pslverr), 32'h0);
    reg_read(ADDR_VERSION, rd);
    check_value("version", rd, {8'd1, 8'd0, 16'h005A});
    reg_read(ADDR_NUM_REGS, rd);
    check_value("num_regs", rd, 32'(8 + 4 * (NUM_ING + NUM_EGR)));
    check_value("ing_port_enable", 32'(ing_port_enable), 32'hF);
    check_value("egr_port_enable", 32'(egr_port_enable), 32'h3);
    for (int w = 0; w < 4 * (NUM_ING + NUM_EGR); w++) begin
        reg_read(ADDR_CNT_BASE + w, rd);
        check_value($sformatf("snapshot word %0d", w), rd, 32'h0);
    end
endtask

task automatic exercise_enables_and_link();
    logic [31:0] rd;
    set_enable(1'b0, 8'hA5);
    set_enable(1'b1, 8'h02);
    set_enable(1'b0, 8'hFF);
    set_enable(1'b1, 8'hFF);
    @(negedge core_clk_ifc);
    ing_link_up = 4'b0110;
    egr_link_up = 2'b10;
    repeat (2) @(negedge core_clk_ifc);
    reg_read(ADDR_ING_LINK_STAT, rd);
    check_value("ing_link_stat", rd, 32'h6);
    reg_read(ADDR_EGR_LINK_STAT, rd);
    check_value("egr_link_stat", rd, 32'h2);
endtask

task automatic count_and_sample_traffic();
    int          p;
    logic [15:0] len;
    for (int i = 0; i < 20; i++) begin
        p   = int'($unsigned($random(seed)) % NUM_ING);
        len = 16'(64 + $unsigned($random(seed)) % 1455);
        send_packet(1'b0, p, len, (i % 4) == 1);
        if (i % 3 == 0) send_drop(1'b0, (p + 1) % NUM_ING);
    end
    send_packet(1'b1, 1, 16'd300, 1'b1);
    send_drop(1'b1, 0);
    sample_and_check(1'b0, 8'h0F);
    sample_and_check(1'b1, 8'h03);
    sample_and_check(1'b0, 8'h0F);              // Counters cleared by the previous sample
    sample_and_check(1'b1, 8'h03);
endtask

task automatic ignore_disabled_port_traffic();
    set_enable(1'b0, 8'h0B);                    // Port 2 off
    send_packet(1'b0, 2, 16'd100, 1'b1);
    send_drop(1'b0, 2);
    send_packet(1'b0, 0, 16'd200, 1'b0);
    sample_and_check(1'b0, 8'h05);
    set_enable(1'b0, 8'hFF);
endtask

task automatic saturate_egress_bytes();
    logic [31:0] rd;
    repeat (70) send_packet(1'b1, 0, 16'd1000, 1'b0);
    sample_and_check(1'b1, 8'h01);
    reg_read(ADDR_CNT_BASE + 4 * NUM_ING + CNT_BYTES, rd);   // Snapshots hold after sampling
    check_value("egress port 0 byte snapshot", rd, 32'd65535);
    reg_read(ADDR_CNT_BASE + 4 * NUM_ING + CNT_PKTS, rd);
    check_value("egress port 0 packet snapshot", rd, 32'd70);
endtask

task automatic provoke_bus_errors();
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b0, 12'h006, 32'h0, rd, err);
    check_value("pslverr unaligned read", 32'(err), 32'h1);
    check_value("prdata unaligned read", rd, 32'h0);
    apb_transfer(1'b0, APB_ADDR_W'(4 * (8 + 4 * (NUM_ING + NUM_EGR))), 32'h0, rd, err);
    check_value("pslverr out of range read", 32'(err), 32'h1);
    check_value("prdata out of range read", rd, 32'h0);
    apb_transfer(1'b1, 12'h00E, 32'h5, rd, err);    // Unaligned address inside egress enable
    check_value("pslverr unaligned write", 32'(err), 32'h1);
    reg_read(ADDR_EGR_ENABLE, rd);
    check_value("egress enable after unaligned write", rd, 32'h3);
    reg_write(ADDR_VERSION, 32'hDEAD_BEEF);
    reg_read(ADDR_VERSION, rd);
    check_value("version after write", rd, {8'd1, 8'd0, 16'h005A});
endtask

// File: verif/router_stats_tb.sv
// Directed testbench for the router statistics block
// Drives APB and packet events into router_stats_top and checks snapshots against a count model

`timescale 1ns/1ps

module router_stats_tb;
    import router_stats_pkg::*;

    localparam int NUM_ING        = 4;
    localparam int NUM_EGR        = 2;
    localparam int CLK_PERIOD     = 40;
    localparam int APB_WAIT_LIMIT = 8;      // Cycles to wait for pready

    ////////////////////////////////////////
    // Watchdog budget from the test lengths
    localparam int APB_XFERS   = 160;
    localparam int XFER_CYCLES = 5;
    localparam int PKT_CYCLES  = 300;
    localparam int WATCHDOG_NS = 2 * (APB_XFERS * XFER_CYCLES + PKT_CYCLES) * CLK_PERIOD;

    logic                  core_clk_ifc;
    logic                  peripheral_sresetn_core;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic                  pready;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pslverr;
    logic [NUM_ING-1:0]    ing_link_up;
    logic [NUM_EGR-1:0]    egr_link_up;
    logic [NUM_ING-1:0]    ing_pkt_valid;
    pkt_len_t              ing_pkt_len [NUM_ING];
    logic [NUM_ING-1:0]    ing_pkt_err;
    logic [NUM_ING-1:0]    ing_buf_full_drop;
    logic [NUM_EGR-1:0]    egr_pkt_valid;
    pkt_len_t              egr_pkt_len [NUM_EGR];
    logic [NUM_EGR-1:0]    egr_pkt_err;
    logic [NUM_EGR-1:0]    egr_buf_full_drop;
    logic [NUM_ING-1:0]    ing_port_enable;
    logic [NUM_EGR-1:0]    egr_port_enable;

    // Expected live counter values by port and counter index
    logic [31:0]          ing_model [NUM_ING][NUM_CNT_PER_PORT];
    logic [31:0]          egr_model [NUM_EGR][NUM_CNT_PER_PORT];
    logic [MAX_PORTS-1:0] ing_en_model;
    logic [MAX_PORTS-1:0] egr_en_model;
    integer               seed;

    router_stats_top #(
        .MODULE_ID     (16'h005A),
        .NUM_ING_PORTS (NUM_ING),
        .NUM_EGR_PORTS (NUM_EGR)
    ) UUT (
        .core_clk_ifc, .peripheral_sresetn_core,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pready, .prdata, .pslverr,
        .ing_link_up, .egr_link_up,
        .ing_pkt_valid, .ing_pkt_len, .ing_pkt_err, .ing_buf_full_drop,
        .egr_pkt_valid, .egr_pkt_len, .egr_pkt_err, .egr_buf_full_drop,
        .ing_port_enable, .egr_port_enable
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1);
    end

    `include "router_stats_tasks.svh"

    initial begin
        seed                    = 95;
        peripheral_sresetn_core = 1'b0;
        paddr                   = '0;
        psel                    = 1'b0;
        penable                 = 1'b0;
        pwrite                  = 1'b0;
        pwdata                  = '0;
        ing_link_up             = '0;
        egr_link_up             = '0;
        ing_pkt_valid           = '0;
        ing_pkt_err             = '0;
        ing_buf_full_drop       = '0;
        egr_pkt_valid           = '0;
        egr_pkt_err             = '0;
        egr_buf_full_drop       = '0;
        ing_en_model            = '1;
        egr_en_model            = '1;
        for (int p = 0; p < NUM_ING; p++) begin
            ing_pkt_len[p] = '0;
            for (int c = 0; c < NUM_CNT_PER_PORT; c++) ing_model[p][c] = '0;
        end
        for (int p = 0; p < NUM_EGR; p++) begin
            egr_pkt_len[p] = '0;
            for (int c = 0; c < NUM_CNT_PER_PORT; c++) egr_model[p][c] = '0;
        end
        repeat (2) @(negedge core_clk_ifc);     // Two reset cycles
        peripheral_sresetn_core = 1'b1;

        verify_reset_identity();
        exercise_enables_and_link();
        count_and_sample_traffic();
        ignore_disabled_port_traffic();
        saturate_egress_bytes();
        provoke_bus_errors();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: source/router_stats_top.sv
// Top level of the router statistics block
// APB access stage, register stage and the ingress and egress counter banks

`timescale 1ns/1ps

module router_stats_top #(
    parameter logic [15:0] MODULE_ID     = 16'h0,
    parameter int          NUM_ING_PORTS = 4,
    parameter int          NUM_EGR_PORTS = 2
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  logic [router_stats_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [router_stats_pkg::APB_DATA_W-1:0] pwdata,
    output logic                                    pready,
    output logic [router_stats_pkg::APB_DATA_W-1:0] prdata,
    output logic                                    pslverr,
    input  logic [NUM_ING_PORTS-1:0]                ing_link_up,
    input  logic [NUM_EGR_PORTS-1:0]                egr_link_up,
    input  logic [NUM_ING_PORTS-1:0]                ing_pkt_valid,
    input  router_stats_pkg::pkt_len_t              ing_pkt_len [NUM_ING_PORTS],
    input  logic [NUM_ING_PORTS-1:0]                ing_pkt_err,
    input  logic [NUM_ING_PORTS-1:0]                ing_buf_full_drop,
    input  logic [NUM_EGR_PORTS-1:0]                egr_pkt_valid,
    input  router_stats_pkg::pkt_len_t              egr_pkt_len [NUM_EGR_PORTS],
    input  logic [NUM_EGR_PORTS-1:0]                egr_pkt_err,
    input  logic [NUM_EGR_PORTS-1:0]                egr_buf_full_drop,
    output logic [NUM_ING_PORTS-1:0]                ing_port_enable,
    output logic [NUM_EGR_PORTS-1:0]                egr_port_enable
);
    import router_stats_pkg::*;

    logic                     reg_wr_en;
    logic                     reg_rd_en;
    logic [REG_ADDR_W-1:0]    reg_word_addr;
    logic [APB_DATA_W-1:0]    reg_wdata;
    logic [APB_DATA_W-1:0]    reg_rdata;
    logic                     reg_addr_err;
    logic [NUM_ING_PORTS-1:0] ing_cnt_clear;
    logic [NUM_EGR_PORTS-1:0] egr_cnt_clear;
    ing_cnt_t ing_cnt_pkts [NUM_ING_PORTS];
    ing_cnt_t ing_cnt_bytes [NUM_ING_PORTS];
    ing_cnt_t ing_cnt_errs [NUM_ING_PORTS];
    ing_cnt_t ing_cnt_drops [NUM_ING_PORTS];
    egr_cnt_t egr_cnt_pkts [NUM_EGR_PORTS];
    egr_cnt_t egr_cnt_bytes [NUM_EGR_PORTS];
    egr_cnt_t egr_cnt_errs [NUM_EGR_PORTS];
    egr_cnt_t egr_cnt_drops [NUM_EGR_PORTS];

    ////////////////////////////////////////
    // Bus and register stages

    apb_reg_access u_apb_reg_access (
        .core_clk_ifc, .peripheral_sresetn_core,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pready, .prdata, .pslverr,
        .reg_wr_en, .reg_rd_en, .reg_word_addr, .reg_wdata, .reg_rdata, .reg_addr_err
    );

    router_port_regs #(
        .MODULE_ID     (MODULE_ID),
        .NUM_ING_PORTS (NUM_ING_PORTS),
        .NUM_EGR_PORTS (NUM_EGR_PORTS)
    ) u_router_port_regs (
        .core_clk_ifc, .peripheral_sresetn_core,
        .reg_wr_en, .reg_rd_en, .reg_word_addr, .reg_wdata, .reg_rdata, .reg_addr_err,
        .ing_link_up, .egr_link_up, .ing_port_enable, .egr_port_enable,
        .ing_cnt_clear, .egr_cnt_clear,
        .ing_cnt_pkts, .ing_cnt_bytes, .ing_cnt_errs, .ing_cnt_drops,
        .egr_cnt_pkts, .egr_cnt_bytes, .egr_cnt_errs, .egr_cnt_drops
    );

    ////////////////////////////////////////
    // Counter banks, 32-bit ingress and 16-bit egress

    port_stats_counters #(
        .NUM_PORTS (NUM_ING_PORTS),
        .cnt_t     (ing_cnt_t)
    ) u_ing_counters (
        .core_clk_ifc, .peripheral_sresetn_core,
        .port_enable   (ing_port_enable),
        .cnt_clear     (ing_cnt_clear),
        .pkt_valid     (ing_pkt_valid),
        .pkt_len       (ing_pkt_len),
        .pkt_err       (ing_pkt_err),
        .buf_full_drop (ing_buf_full_drop),
        .cnt_pkts      (ing_cnt_pkts),
        .cnt_bytes     (ing_cnt_bytes),
        .cnt_errs      (ing_cnt_errs),
        .cnt_drops     (ing_cnt_drops)
    );

    port_stats_counters #(
        .NUM_PORTS (NUM_EGR_PORTS),
        .cnt_t     (egr_cnt_t)
    ) u_egr_counters (
        .core_clk_ifc, .peripheral_sresetn_core,
        .port_enable   (egr_port_enable),
        .cnt_clear     (egr_cnt_clear),
        .pkt_valid     (egr_pkt_valid),
        .pkt_len       (egr_pkt_len),
        .pkt_err       (egr_pkt_err),
        .buf_full_drop (egr_buf_full_drop),
        .cnt_pkts      (egr_cnt_pkts),
        .cnt_bytes     (egr_cnt_bytes),
        .cnt_errs      (egr_cnt_errs),
        .cnt_drops     (egr_cnt_drops)
    );

endmodule

// File: source/port_stats_counters.sv
// Saturating packet, byte, error and drop counters for one direction
// cnt_t selects the counter width, so one module serves ingress and egress

`timescale 1ns/1ps

module port_stats_counters #(
    parameter int  NUM_PORTS = 4,
    parameter type cnt_t     = logic [31:0]
) (
    input  logic                       core_clk_ifc,
    input  logic                       peripheral_sresetn_core,
    input  logic [NUM_PORTS-1:0]       port_enable,
    input  logic [NUM_PORTS-1:0]       cnt_clear,
    input  logic [NUM_PORTS-1:0]       pkt_valid,
    input  router_stats_pkg::pkt_len_t pkt_len [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]       pkt_err,
    input  logic [NUM_PORTS-1:0]       buf_full_drop,
    output cnt_t                       cnt_pkts  [NUM_PORTS],
    output cnt_t                       cnt_bytes [NUM_PORTS],
    output cnt_t                       cnt_errs  [NUM_PORTS],
    output cnt_t                       cnt_drops [NUM_PORTS]
);
    import router_stats_pkg::*;

    localparam int CW = $bits(cnt_t);

    // Add with clamp at the all-ones value of cnt_t
    function automatic cnt_t sat_add(input cnt_t base, input pkt_len_t inc);
        logic [CW:0] sum;
        sum = {1'b0, base} + (CW+1)'(inc);
        if (sum[CW]) begin
            return '1;
        end
        return sum[CW-1:0];
    endfunction

    ////////////////////////////////////////
    // Counter update

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                cnt_pkts[p]  <= '0;
                cnt_bytes[p] <= '0;
                cnt_errs[p]  <= '0;
                cnt_drops[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin         // Clear beats a same-cycle event
                    cnt_pkts[p]  <= '0;
                    cnt_bytes[p] <= '0;
                    cnt_errs[p]  <= '0;
                    cnt_drops[p] <= '0;
                end else if (port_enable[p]) begin
                    if (pkt_valid[p]) begin
                        cnt_pkts[p]  <= sat_add(cnt_pkts[p], pkt_len_t'(1));
                        cnt_bytes[p] <= sat_add(cnt_bytes[p], pkt_len[p]);
                        if (pkt_err[p]) begin
                            cnt_errs[p] <= sat_add(cnt_errs[p], pkt_len_t'(1));
                        end
                    end
                    if (buf_full_drop[p]) begin
                        cnt_drops[p] <= sat_add(cnt_drops[p], pkt_len_t'(1));
                    end
                end
            end
        end
    end

endmodule

// File: source/router_port_regs.sv
// Register file for port enables, link status and counter sampling
// Sits behind apb_reg_access and drives enables and clears to both counter banks

`timescale 1ns/1ps

module router_port_regs #(
    parameter logic [15:0] MODULE_ID     = 16'h0,
    parameter int          NUM_ING_PORTS = 4,
    parameter int          NUM_EGR_PORTS = 2
) (
    input  logic                                    core_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  logic                                    reg_wr_en,
    input  logic                                    reg_rd_en,
    input  logic [router_stats_pkg::REG_ADDR_W-1:0] reg_word_addr,
    input  logic [router_stats_pkg::APB_DATA_W-1:0] reg_wdata,
    output logic [router_stats_pkg::APB_DATA_W-1:0] reg_rdata,
    output logic                                    reg_addr_err,
    input  logic [NUM_ING_PORTS-1:0]                ing_link_up,
    input  logic [NUM_EGR_PORTS-1:0]                egr_link_up,
    output logic [NUM_ING_PORTS-1:0]                ing_port_enable,
    output logic [NUM_EGR_PORTS-1:0]                egr_port_enable,
    output logic [NUM_ING_PORTS-1:0]                ing_cnt_clear,
    output logic [NUM_EGR_PORTS-1:0]                egr_cnt_clear,
    input  router_stats_pkg::ing_cnt_t              ing_cnt_pkts  [NUM_ING_PORTS],
    input  router_stats_pkg::ing_cnt_t              ing_cnt_bytes [NUM_ING_PORTS],
    input  router_stats_pkg::ing_cnt_t              ing_cnt_errs  [NUM_ING_PORTS],
    input  router_stats_pkg::ing_cnt_t              ing_cnt_drops [NUM_ING_PORTS],
    input  router_stats_pkg::egr_cnt_t              egr_cnt_pkts  [NUM_EGR_PORTS],
    input  router_stats_pkg::egr_cnt_t              egr_cnt_bytes [NUM_EGR_PORTS],
    input  router_stats_pkg::egr_cnt_t              egr_cnt_errs  [NUM_EGR_PORTS],
    input  router_stats_pkg::egr_cnt_t              egr_cnt_drops [NUM_EGR_PORTS]
);
    import router_stats_pkg::*;

    localparam int NUM_SNAP   = NUM_CNT_PER_PORT * (NUM_ING_PORTS + NUM_EGR_PORTS);
    localparam int TOTAL_REGS = ADDR_CNT_BASE + NUM_SNAP;

    localparam logic [APB_DATA_W-1:0] VERSION_WORD = {VERSION_MAJOR, VERSION_MINOR, MODULE_ID};
    // Valid-port masks, also the enable reset values
    localparam logic [MAX_PORTS-1:0] ING_MASK = {MAX_PORTS{1'b1}} >> (MAX_PORTS - NUM_ING_PORTS);
    localparam logic [MAX_PORTS-1:0] EGR_MASK = {MAX_PORTS{1'b1}} >> (MAX_PORTS - NUM_EGR_PORTS);

    logic [MAX_PORTS-1:0]     ing_enable_q;
    logic [MAX_PORTS-1:0]     egr_enable_q;
    logic [MAX_PORTS-1:0]     ing_sample_q;
    logic [MAX_PORTS-1:0]     egr_sample_q;
    logic [NUM_ING_PORTS-1:0] ing_link_q;
    logic [NUM_EGR_PORTS-1:0] egr_link_q;
    logic [NUM_ING_PORTS-1:0] ing_sample_req;
    logic [NUM_ING_PORTS-1:0] ing_sample_req_d;
    logic [NUM_EGR_PORTS-1:0] egr_sample_req;
    logic [NUM_EGR_PORTS-1:0] egr_sample_req_d;
    logic [NUM_ING_PORTS-1:0] ing_rise;
    logic [NUM_EGR_PORTS-1:0] egr_rise;
    logic [APB_DATA_W-1:0]    snap [NUM_SNAP];      // Ingress groups first, then egress
    logic [APB_DATA_W-1:0]    rd_word;

    ////////////////////////////////////////
    // Register writes

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_enable_q <= ING_MASK;
            egr_enable_q <= EGR_MASK;
            ing_sample_q <= '0;
            egr_sample_q <= '0;
        end else if (reg_wr_en) begin
            case (reg_word_addr)
                ADDR_ING_ENABLE: ing_enable_q <= reg_wdata[MAX_PORTS-1:0] & ING_MASK;
                ADDR_EGR_ENABLE: egr_enable_q <= reg_wdata[MAX_PORTS-1:0] & EGR_MASK;
                ADDR_ING_SAMPLE: ing_sample_q <= reg_wdata[MAX_PORTS-1:0] & ING_MASK;
                ADDR_EGR_SAMPLE: egr_sample_q <= reg_wdata[MAX_PORTS-1:0] & EGR_MASK;
                default: ;          // Read-only words ignore writes
            endcase
        end
    end

    ////////////////////////////////////////
    // Status, sample edges and snapshots

    assign ing_rise = ing_sample_req & ~ing_sample_req_d;
    assign egr_rise = egr_sample_req & ~egr_sample_req_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_port_enable  <= '1;
            egr_port_enable  <= '1;
            ing_link_q       <= '0;
            egr_link_q       <= '0;
            ing_sample_req   <= '0;
            ing_sample_req_d <= '0;
            egr_sample_req   <= '0;
            egr_sample_req_d <= '0;
            ing_cnt_clear    <= '0;
            egr_cnt_clear    <= '0;
            for (int i = 0; i < NUM_SNAP; i++) begin
                snap[i] <= '0;
            end
        end else begin
            ing_port_enable  <= ing_enable_q[NUM_ING_PORTS-1:0];
            egr_port_enable  <= egr_enable_q[NUM_EGR_PORTS-1:0];
            ing_link_q       <= ing_link_up;
            egr_link_q       <= egr_link_up;
            ing_sample_req   <= ing_sample_q[NUM_ING_PORTS-1:0];
            ing_sample_req_d <= ing_sample_req;
            egr_sample_req   <= egr_sample_q[NUM_EGR_PORTS-1:0];
            egr_sample_req_d <= egr_sample_req;
            ing_cnt_clear    <= ing_rise;   // Snapshot and clear in the same edge
            egr_cnt_clear    <= egr_rise;

            for (int p = 0; p < NUM_ING_PORTS; p++) begin
                if (ing_rise[p]) begin
                    snap[NUM_CNT_PER_PORT*p + CNT_PKTS]  <= APB_DATA_W'(ing_cnt_pkts[p]);
                    snap[NUM_CNT_PER_PORT*p + CNT_BYTES] <= APB_DATA_W'(ing_cnt_bytes[p]);
                    snap[NUM_CNT_PER_PORT*p + CNT_ERRS]  <= APB_DATA_W'(ing_cnt_errs[p]);
                    snap[NUM_CNT_PER_PORT*p + CNT_DROPS] <= APB_DATA_W'(ing_cnt_drops[p]);
                end
            end
            // Egress groups follow the last ingress port
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (egr_rise[p]) begin
                    snap[NUM_CNT_PER_PORT*(NUM_ING_PORTS+p) + CNT_PKTS]
                        <= APB_DATA_W'(egr_cnt_pkts[p]);
                    snap[NUM_CNT_PER_PORT*(NUM_ING_PORTS+p) + CNT_BYTES]
                        <= APB_DATA_W'(egr_cnt_bytes[p]);
                    snap[NUM_CNT_PER_PORT*(NUM_ING_PORTS+p) + CNT_ERRS]
                        <= APB_DATA_W'(egr_cnt_errs[p]);
                    snap[NUM_CNT_PER_PORT*(NUM_ING_PORTS+p) + CNT_DROPS]
                        <= APB_DATA_W'(egr_cnt_drops[p]);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Read path

    always_comb begin
        rd_word = '0;
        case (reg_word_addr)
            ADDR_VERSION:       rd_word = VERSION_WORD;
            ADDR_NUM_REGS:      rd_word = APB_DATA_W'(TOTAL_REGS);
            ADDR_ING_ENABLE:    rd_word = APB_DATA_W'(ing_enable_q);
            ADDR_EGR_ENABLE:    rd_word = APB_DATA_W'(egr_enable_q);
            ADDR_ING_LINK_STAT: rd_word = APB_DATA_W'(ing_link_q);
            ADDR_EGR_LINK_STAT: rd_word = APB_DATA_W'(egr_link_q);
            ADDR_ING_SAMPLE:    rd_word = APB_DATA_W'(ing_sample_q);
            ADDR_EGR_SAMPLE:    rd_word = APB_DATA_W'(egr_sample_q);
            default: begin
                if (reg_word_addr < TOTAL_REGS) begin
                    rd_word = snap[reg_word_addr - ADDR_CNT_BASE];
                end
            end
        endcase
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reg_rd_en) begin
            reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            reg_addr_err <= 1'b0;
        end else begin
            reg_addr_err <= (reg_wr_en | reg_rd_en) && (reg_word_addr >= TOTAL_REGS);
        end
    end

endmodule

// File: source/apb_reg_access.sv
// APB slave front end, one wait state per transfer
// Turns each transfer into a single read or write strobe for the register file

`timescale 1ns/1ps

module apb_reg_access (
    input  logic                                    core_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  logic [router_stats_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [router_stats_pkg::APB_DATA_W-1:0] pwdata,
    output logic                                    pready,
    output logic [router_stats_pkg::APB_DATA_W-1:0] prdata,
    output logic                                    pslverr,
    output logic                                    reg_wr_en,
    output logic                                    reg_rd_en,
    output logic [router_stats_pkg::REG_ADDR_W-1:0] reg_word_addr,
    output logic [router_stats_pkg::APB_DATA_W-1:0] reg_wdata,
    input  logic [router_stats_pkg::APB_DATA_W-1:0] reg_rdata,
    input  logic                                    reg_addr_err
);
    import router_stats_pkg::*;

    logic access_q;     // High in the second access cycle
    logic unaligned_q;
    logic first_access;
    logic unaligned;

    assign first_access = psel & penable & ~access_q;
    assign unaligned    = |paddr[1:0];

    ////////////////////////////////////////
    // Strobes to the register file

    assign reg_wr_en     = first_access & pwrite & ~unaligned;   // Unaligned writes dropped
    assign reg_rd_en     = first_access & ~pwrite;
    assign reg_word_addr = paddr[APB_ADDR_W-1:2];
    assign reg_wdata     = pwdata;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            access_q    <= 1'b0;
            unaligned_q <= 1'b0;
        end else begin
            access_q <= first_access;     // Drops again after one cycle
            if (first_access) begin
                unaligned_q <= unaligned;
            end
        end
    end

    ////////////////////////////////////////
    // Completion

    assign pready  = access_q;
    assign pslverr = access_q & (unaligned_q | reg_addr_err);
    // Unaligned reads return zero
    assign prdata  = (access_q && !unaligned_q) ? reg_rdata : '0;

endmodule

// File: source/router_stats_pkg.sv
// Shared widths, register map and counter types for the router statistics block
// Imported by every RTL module of the statistics and control corner

package router_stats_pkg;

    ////////////////////////////////////////
    // Bus widths

    localparam int APB_ADDR_W = 12;                // Byte address
    localparam int APB_DATA_W = 32;
    localparam int REG_ADDR_W = APB_ADDR_W - 2;    // Word address

    localparam int MAX_PORTS = 8;                  // Per direction, one bit each in enable/sample

    ////////////////////////////////////////
    // Register word addresses

    localparam int ADDR_VERSION       = 0;
    localparam int ADDR_NUM_REGS      = 1;
    localparam int ADDR_ING_ENABLE    = 2;
    localparam int ADDR_EGR_ENABLE    = 3;
    localparam int ADDR_ING_LINK_STAT = 4;
    localparam int ADDR_EGR_LINK_STAT = 5;
    localparam int ADDR_ING_SAMPLE    = 6;
    localparam int ADDR_EGR_SAMPLE    = 7;
    localparam int ADDR_CNT_BASE      = 8;         // Ingress snapshots, then egress

    // Counter order inside one port's group of four
    localparam int NUM_CNT_PER_PORT = 4;
    localparam int CNT_PKTS         = 0;
    localparam int CNT_BYTES        = 1;
    localparam int CNT_ERRS         = 2;
    localparam int CNT_DROPS        = 3;

    localparam logic [7:0] VERSION_MAJOR = 8'd1;
    localparam logic [7:0] VERSION_MINOR = 8'd0;

    ////////////////////////////////////////
    // Payload types

    typedef logic [31:0] ing_cnt_t;
    typedef logic [15:0] egr_cnt_t;
    typedef logic [15:0] pkt_len_t;

endpackage
